//--- list.f
hdl/stream_mac_pkg.sv
hdl/wb_wu_front.sv
hdl/stream_reader.sv
hdl/mac_combiner.sv
hdl/stream_mac_top.sv
tests/tb_clock_gen.sv
tests/stream_mac_checker.sv
tests/stream_mac_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = stream_mac_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/stream_mac_tb.sv
// Stream MAC testbench
// Random work units over Wishbone, results checked against a bank model

`timescale 1ns/1ps

module stream_mac_tb;

    localparam int N_DOT    = 6;
    localparam int N_SCALE  = 4;
    localparam int MAX_LEN  = 255;
    // Reset, dot runs, scale runs, busy pair, corner trio
    localparam int NUM_RUNS = 1 + N_DOT + N_SCALE + 2 + 3;
    // Both operand regions per run
    localparam int MAX_WR   = 2 * MAX_LEN;
    localparam int CYCLE_LIMIT = NUM_RUNS * (2 * MAX_WR + 4 * MAX_LEN + 100);

    logic        clk2x;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [11:0] wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic        wb_ack;

    // Mirror of both banks
    logic [15:0] model_a [0:1023];
    logic [15:0] model_b [0:1023];
    logic [31:0] lcg_state;
    int          cycle_count = 0;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(10)) clk_gen_i
    (
        .clk2x (clk2x),
        .rst_n (rst_n)
    );

    stream_mac_top #(.BUF_DEPTH(2)) stream_mac_top_i
    (
        .clk2x    (clk2x),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    // ----------------------------------------
    // Random numbers and reference model
    // ----------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // High half only, low LCG bits are weak
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:16]) % n;
    endfunction

    // Half the bases sit just below 1023 so streams wrap
    function automatic int rand_base();
        if (rand_below(2) == 1)
            return 1023 - rand_below(16);
        else
            return rand_below(1024);
    endfunction

    // Sum of unsigned 16x16 products, modulo 2^32
    function automatic logic [31:0] model_result(input logic scale_mode, input int len,
                                                 input int base_a, input int field);
        logic [31:0] acc;
        logic [15:0] opb;
        acc = '0;
        for (int i = 0; i < len; i++)
        begin
            opb = scale_mode ? 16'(field) : model_b[(field + i) % 1024];
            acc = acc + 32'(model_a[(base_a + i) % 1024]) * 32'(opb);
        end
        return acc;
    endfunction

    // ----------------------------------------
    // Wishbone host tasks
    // ----------------------------------------
    task automatic wb_access(input logic we, input logic [11:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        @(posedge clk2x);
        #1;
        // Watchdog covers a missing ack
        while (!wb_ack)
        begin
            @(posedge clk2x);
            #1;
        end
        rdata = wb_rdata;
        // Write lands on this edge
        @(posedge clk2x);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [11:0] adr, input logic [31:0] wdata);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdata, unused);
    endtask

    task automatic wb_read(input logic [11:0] adr, output logic [31:0] rdata);
        wb_access(1'b0, adr, 32'h0, rdata);
    endtask

    // Upper half of the data word is noise the bank must ignore
    task automatic bank_write(input logic to_b, input int addr, input logic [15:0] value,
                              input logic update_model);
        logic [1:0] sel;
        sel = to_b ? stream_mac_pkg::BANK_B_SEL : stream_mac_pkg::BANK_A_SEL;
        wb_write({sel, 10'(addr)}, {16'(lcg_next()), value});
        if (update_model && to_b)
            model_b[addr % 1024] = value;
        else if (update_model)
            model_a[addr % 1024] = value;
    endtask

    task automatic fill_region(input logic to_b, input int base, input int len);
        logic [31:0] r;
        for (int i = 0; i < len; i++)
        begin
            r = lcg_next();
            bank_write(to_b, (base + i) % 1024, r[31:16], 1'b1);
        end
    endtask

    // Work-unit word: op, len, base_a, base_b or scale
    task automatic send_unit(input logic [3:0] op, input int len, input int base_a,
                             input int field);
        wb_write(stream_mac_pkg::REG_CTRL, {op, 8'(len), 10'(base_a), 10'(field)});
    endtask

    task automatic wait_done();
        logic [31:0] status;
        status = '0;
        while (!(!status[stream_mac_pkg::STAT_BUSY_BIT] &&
                 status[stream_mac_pkg::STAT_DONE_BIT]))
            wb_read(stream_mac_pkg::REG_CTRL, status);
    endtask

    // ----------------------------------------
    // Checks and per-test reporting
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        test_checks++;
        assert (got === expected)
        else
        begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h",
                     $time, name, got, expected);
            test_errors++;
        end
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_checks += test_checks;
        total_errors += test_errors;
        if (test_errors != 0)
            tests_failed++;
        $display("TEST %s: %s (%0d checks, %0d errors)", name,
                 (test_errors == 0) ? "PASS" : "FAIL", test_checks, test_errors);
    endtask

    // Fill, launch, poll, compare
    task automatic run_unit(input logic scale_mode, input int len, input int base_a,
                            input int field);
        logic [31:0] rd;
        logic [31:0] expected;
        fill_region(1'b0, base_a, len);
        // Scale mode gets junk in bank B somewhere
        fill_region(1'b1, scale_mode ? rand_base() : field, len);
        expected = model_result(scale_mode, len, base_a, field);
        send_unit(scale_mode ? stream_mac_pkg::OP_SCALE : stream_mac_pkg::OP_DOT,
                  len, base_a, field);
        wait_done();
        wb_read(stream_mac_pkg::REG_RESULT, rd);
        check_value("result", rd, expected);
    endtask

    // Cycle budget for the whole run
    always @(posedge clk2x)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("ERROR: timeout after %0d cycles, the DUT stopped responding",
                     cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial
    begin
        logic [31:0] rd;
        logic [31:0] status0;
        logic [31:0] exp1;
        int          base_a;
        int          base_b;
        lcg_state    = 32'hd54c;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_wdata     = '0;
        tests_run    = 0;
        tests_failed = 0;
        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < 1024; i++)
        begin
            model_a[i] = '0;
            model_b[i] = '0;
        end
        wait (rst_n === 1'b1);
        @(posedge clk2x);
        #1;

        // Reset values and zero read-back
        start_test();
        wb_read(stream_mac_pkg::REG_CTRL, rd);
        check_value("status", rd, 32'h0);
        wb_read(stream_mac_pkg::REG_RESULT, rd);
        check_value("result", rd, 32'h0);
        wb_read(12'h002, rd);
        check_value("unmapped_rdata", rd, 32'h0);
        wb_read(12'hc05, rd);
        check_value("unmapped_rdata", rd, 32'h0);
        bank_write(1'b0, 5, 16'hbeef, 1'b1);
        bank_write(1'b1, 5, 16'hcafe, 1'b1);
        wb_read(12'h405, rd);
        check_value("bank_a_rdata", rd, 32'h0);
        wb_read(12'h805, rd);
        check_value("bank_b_rdata", rd, 32'h0);
        finish_test("reset_readback");

        start_test();
        for (int n = 0; n < N_DOT; n++)
            run_unit(1'b0, 1 + rand_below(MAX_LEN), rand_base(), rand_base());
        finish_test("random_dot");

        start_test();
        for (int n = 0; n < N_SCALE; n++)
            run_unit(1'b1, 1 + rand_below(MAX_LEN), rand_base(), rand_below(1024));
        finish_test("random_scale");

        // Long run, then traffic that must be dropped
        start_test();
        base_a = rand_base();
        base_b = rand_base();
        fill_region(1'b0, base_a, MAX_LEN);
        fill_region(1'b1, base_b, MAX_LEN);
        exp1 = model_result(1'b0, MAX_LEN, base_a, base_b);
        send_unit(stream_mac_pkg::OP_DOT, MAX_LEN, base_a, base_b);
        wb_read(stream_mac_pkg::REG_CTRL, rd);
        check_value("status_busy", 32'(rd[stream_mac_pkg::STAT_BUSY_BIT]), 32'h1);
        send_unit(stream_mac_pkg::OP_DOT, 3, base_b, base_a);
        for (int k = 0; k < 8; k++)
        begin
            bank_write(1'b0, (base_a + k) % 1024, 16'(lcg_next()), 1'b0);
            bank_write(1'b1, (base_b + k) % 1024, 16'(lcg_next()), 1'b0);
        end
        wb_read(stream_mac_pkg::REG_CTRL, rd);
        check_value("status_busy", 32'(rd[stream_mac_pkg::STAT_BUSY_BIT]), 32'h1);
        wait_done();
        wb_read(stream_mac_pkg::REG_RESULT, rd);
        check_value("result", rd, exp1);
        // Same unit again sees the old bank contents
        send_unit(stream_mac_pkg::OP_DOT, MAX_LEN, base_a, base_b);
        wait_done();
        wb_read(stream_mac_pkg::REG_RESULT, rd);
        check_value("result", rd, exp1);
        finish_test("busy_drop");

        start_test();
        wb_read(stream_mac_pkg::REG_CTRL, status0);
        send_unit(4'hf, 5, base_a, base_b);
        wb_read(stream_mac_pkg::REG_CTRL, rd);
        check_value("status", rd, status0);
        send_unit(4'h0, 5, base_a, base_b);
        wb_read(stream_mac_pkg::REG_CTRL, rd);
        check_value("status", rd, status0);
        // Empty stream
        send_unit(stream_mac_pkg::OP_DOT, 0, base_a, base_b);
        wait_done();
        wb_read(stream_mac_pkg::REG_RESULT, rd);
        check_value("result", rd, 32'h0);
        wb_read(stream_mac_pkg::REG_CTRL, rd);
        check_value("status", rd, 32'h2);
        // Fresh unit clears done
        send_unit(stream_mac_pkg::OP_DOT, MAX_LEN, base_a, base_b);
        wb_read(stream_mac_pkg::REG_CTRL, rd);
        check_value("status", rd, 32'h1);
        wait_done();
        wb_read(stream_mac_pkg::REG_RESULT, rd);
        check_value("result", rd, exp1);
        finish_test("corner_cases");

        $display("SUMMARY: %0d tests, %0d failed, %0d checks, %0d errors, %0d cycles",
                 tests_run, tests_failed, total_checks, total_errors, cycle_count);
        if (total_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- tests/stream_mac_checker.sv
// Wishbone handshake checker
// Bound onto the stream MAC top level, flags protocol violations on the slave port

`timescale 1ns/1ps

module stream_mac_checker
(
    input logic        clk2x,
    input logic        rst_n,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_we,
    input logic [31:0] wb_rdata,
    input logic        wb_ack
);

    // Ack only inside an active strobe
    ack_inside_strobe: assert property (@(posedge clk2x) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack raised without wb_cyc and wb_stb");

    // Single-cycle ack
    ack_single_cycle: assert property (@(posedge clk2x) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held for two cycles in a row");

    // Read data fully defined when acked
    rdata_known: assert property (@(posedge clk2x) disable iff (!rst_n)
        (wb_ack && !wb_we) |-> !$isunknown(wb_rdata))
        else $error("wb_rdata has unknown bits during a read ack");

endmodule

bind stream_mac_top stream_mac_checker checker_i
(
    .clk2x    (clk2x),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack)
);

//--- tests/tb_clock_gen.sv
// Testbench clock and reset source
// Free-running clk2x and an active-low reset held for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
)
(
    output logic clk2x,
    output logic rst_n
);

    initial
    begin
        clk2x = 1'b0;
        forever
            #(PERIOD / 2) clk2x = ~clk2x;
    end

    // Release just after an edge, away from the DUT sampling point
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk2x);
        #1;
        rst_n = 1'b1;
    end

endmodule

//--- hdl/stream_mac_top.sv
// Stream MAC top level
// Front end, two bank readers and the combiner

`timescale 1ns/1ps

module stream_mac_top
#(
    parameter int BUF_DEPTH = 2
)
(
    input  logic                                clk2x,
    input  logic                                rst_n,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [stream_mac_pkg::WB_AW-1:0]    wb_adr,
    input  logic [31:0]                         wb_wdata,
    output logic [31:0]                         wb_rdata,
    output logic                                wb_ack
);

    // Bank write path
    logic                              bank_we_a;
    logic                              bank_we_b;
    logic [stream_mac_pkg::ADDR_W-1:0] bank_addr;
    logic [stream_mac_pkg::DATA_W-1:0] bank_wdata;
    // Work-unit launch
    logic                              start_a;
    logic                              start_b;
    logic [stream_mac_pkg::ADDR_W-1:0] base_a;
    logic [stream_mac_pkg::ADDR_W-1:0] base_b;
    logic [stream_mac_pkg::LEN_W-1:0]  len;
    logic                              comb_start;
    logic                              scale_en;
    logic [stream_mac_pkg::DATA_W-1:0] scale;
    // Streams into the combiner
    logic [stream_mac_pkg::DATA_W-1:0] a_data;
    logic                              a_valid;
    logic                              a_ready;
    logic [stream_mac_pkg::DATA_W-1:0] b_data;
    logic                              b_valid;
    logic                              b_ready;
    // Completion
    logic                              comb_done;
    logic [stream_mac_pkg::ACC_W-1:0]  result;

    wb_wu_front front_i
    (
        .clk2x      (clk2x),      .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),     .wb_stb     (wb_stb),
        .wb_we      (wb_we),      .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),   .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack),
        .bank_we_a  (bank_we_a),  .bank_we_b  (bank_we_b),
        .bank_addr  (bank_addr),  .bank_wdata (bank_wdata),
        .start_a    (start_a),    .start_b    (start_b),
        .base_a     (base_a),     .base_b     (base_b),
        .len        (len),        .comb_start (comb_start),
        .scale_en   (scale_en),   .scale      (scale),
        .done       (comb_done),  .result     (result)
    );

    // ----------------------------------------
    // Operand streams
    // ----------------------------------------
    stream_reader #(.BUF_DEPTH(BUF_DEPTH)) rd_a
    (
        .clk2x      (clk2x),      .rst_n      (rst_n),
        .bank_we    (bank_we_a),  .bank_addr  (bank_addr),
        .bank_wdata (bank_wdata),
        .start      (start_a),    .base       (base_a),
        .len        (len),        .ready      (a_ready),
        .data       (a_data),     .valid      (a_valid)
    );

    stream_reader #(.BUF_DEPTH(BUF_DEPTH)) rd_b
    (
        .clk2x      (clk2x),      .rst_n      (rst_n),
        .bank_we    (bank_we_b),  .bank_addr  (bank_addr),
        .bank_wdata (bank_wdata),
        .start      (start_b),    .base       (base_b),
        .len        (len),        .ready      (b_ready),
        .data       (b_data),     .valid      (b_valid)
    );

    mac_combiner comb_i
    (
        .clk2x      (clk2x),      .rst_n      (rst_n),
        .start      (comb_start), .len        (len),
        .scale_en   (scale_en),   .scale      (scale),
        .a_data     (a_data),     .a_valid    (a_valid),
        .a_ready    (a_ready),
        .b_data     (b_data),     .b_valid    (b_valid),
        .b_ready    (b_ready),
        .done       (comb_done),  .result     (result)
    );

endmodule

//--- hdl/mac_combiner.sv
// Multiply-accumulate combiner
// Joins two operand streams, or stream A with a constant, into one sum

`timescale 1ns/1ps

module mac_combiner
(
    input  logic                                clk2x,
    input  logic                                rst_n,
    // Run control
    input  logic                                start,
    input  logic [stream_mac_pkg::LEN_W-1:0]    len,
    input  logic                                scale_en,
    input  logic [stream_mac_pkg::DATA_W-1:0]   scale,
    // Stream A
    input  logic [stream_mac_pkg::DATA_W-1:0]   a_data,
    input  logic                                a_valid,
    output logic                                a_ready,
    // Stream B
    input  logic [stream_mac_pkg::DATA_W-1:0]   b_data,
    input  logic                                b_valid,
    output logic                                b_ready,
    // Completion
    output logic                                done,
    output logic [stream_mac_pkg::ACC_W-1:0]    result
);

    logic [stream_mac_pkg::LEN_W-1:0]  remain_q;
    logic [stream_mac_pkg::DATA_W-1:0] mult_b;
    logic [stream_mac_pkg::ACC_W-1:0]  prod_d;
    logic [stream_mac_pkg::ACC_W-1:0]  prod_q;
    logic                              prod_v_q;
    logic                              prod_last_q;
    logic [stream_mac_pkg::ACC_W-1:0]  acc_q;
    logic                              take;
    logic                              running;

    // ----------------------------------------
    // Pair join
    // ----------------------------------------
    assign running = (remain_q != '0);
    // B is ignored entirely in scale mode
    assign take    = running && a_valid && (scale_en || b_valid);
    assign a_ready = running && (scale_en || b_valid);
    assign b_ready = running && a_valid && !scale_en;

    assign mult_b = scale_en ? scale : b_data;
    // Full 32-bit unsigned product
    assign prod_d = a_data * mult_b;

    // ----------------------------------------
    // Two-stage multiply-accumulate
    // ----------------------------------------
    always_ff @(posedge clk2x or negedge rst_n)
    begin
        if (!rst_n)
        begin
            remain_q    <= '0;
            prod_v_q    <= 1'b0;
            prod_last_q <= 1'b0;
            acc_q       <= '0;
            done        <= 1'b0;
        end
        else
        begin
            prod_v_q    <= take;
            prod_last_q <= take && (remain_q == 1);
            // Empty run finishes right away
            done        <= (start && (len == '0)) || (prod_v_q && prod_last_q);
            if (start)
            begin
                remain_q <= len;
                acc_q    <= '0;
            end
            else
            begin
                if (take)
                    remain_q <= remain_q - 1'b1;
                // Sum wraps modulo 2^32
                if (prod_v_q)
                    acc_q <= acc_q + prod_q;
            end
        end
    end

    // Product stage register
    always_ff @(posedge clk2x)
    begin
        if (take)
            prod_q <= prod_d;
    end

    assign result = acc_q;

endmodule

//--- hdl/stream_reader.sv
// Operand stream reader
// One bank with a wrapping address sequencer and a credit-counted output FIFO

`timescale 1ns/1ps

module stream_reader
#(
    parameter int BUF_DEPTH = 2
)
(
    input  logic                                clk2x,
    input  logic                                rst_n,
    // Host write port
    input  logic                                bank_we,
    input  logic [stream_mac_pkg::ADDR_W-1:0]   bank_addr,
    input  logic [stream_mac_pkg::DATA_W-1:0]   bank_wdata,
    // Stream launch
    input  logic                                start,
    input  logic [stream_mac_pkg::ADDR_W-1:0]   base,
    input  logic [stream_mac_pkg::LEN_W-1:0]    len,
    // Output stream
    input  logic                                ready,
    output logic [stream_mac_pkg::DATA_W-1:0]   data,
    output logic                                valid
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [stream_mac_pkg::DATA_W-1:0] mem [0:(1 << stream_mac_pkg::ADDR_W)-1];
    logic [stream_mac_pkg::DATA_W-1:0] fifo_q [0:BUF_DEPTH-1];

    logic [stream_mac_pkg::ADDR_W-1:0] addr_q;
    logic [stream_mac_pkg::ADDR_W-1:0] cur_addr;
    logic [stream_mac_pkg::LEN_W-1:0]  remain_q;
    logic [stream_mac_pkg::LEN_W-1:0]  cur_remain;
    logic [stream_mac_pkg::DATA_W-1:0] rd_q;
    logic                              rd_valid_q;
    logic [PTR_W-1:0]                  wptr_q;
    logic [PTR_W-1:0]                  rptr_q;
    logic [CNT_W-1:0]                  count_q;
    logic [CNT_W:0]                    occupied;
    logic                              issue;
    logic                              pop;

    // Bank storage
    always_ff @(posedge clk2x)
    begin
        if (bank_we)
            mem[bank_addr] <= bank_wdata;
    end

    // ----------------------------------------
    // Address sequencer
    // ----------------------------------------
    // Start cycle doubles as the first address cycle
    assign cur_addr   = start ? base : addr_q;
    assign cur_remain = start ? len : remain_q;

    // Buffered plus in-flight words, less the one leaving now
    assign occupied = count_q + rd_valid_q - pop;
    assign issue    = (cur_remain != '0) && (occupied < BUF_DEPTH);

    always_ff @(posedge clk2x or negedge rst_n)
    begin
        if (!rst_n)
        begin
            addr_q     <= '0;
            remain_q   <= '0;
            rd_valid_q <= 1'b0;
        end
        else
        begin
            // Address wraps at the bank size
            addr_q     <= issue ? cur_addr + 1'b1 : cur_addr;
            remain_q   <= issue ? cur_remain - 1'b1 : cur_remain;
            rd_valid_q <= issue;
        end
    end

    // One cycle of read latency
    always_ff @(posedge clk2x)
    begin
        if (issue)
            rd_q <= mem[cur_addr];
    end

    // ----------------------------------------
    // Output FIFO
    // ----------------------------------------
    assign valid = (count_q != '0);
    assign data  = fifo_q[rptr_q];
    assign pop   = valid && ready;

    always_ff @(posedge clk2x)
    begin
        if (rd_valid_q)
            fifo_q[wptr_q] <= rd_q;
    end

    always_ff @(posedge clk2x or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end
        else
        begin
            if (rd_valid_q)
                wptr_q <= (wptr_q == PTR_W'(BUF_DEPTH - 1)) ? '0 : wptr_q + 1'b1;
            if (pop)
                rptr_q <= (rptr_q == PTR_W'(BUF_DEPTH - 1)) ? '0 : rptr_q + 1'b1;
            count_q <= count_q + CNT_W'(rd_valid_q) - CNT_W'(pop);
        end
    end

endmodule

//--- hdl/wb_wu_front.sv
// Wishbone classic slave front end
// Steers bank writes, decodes work units and keeps busy and done status

`timescale 1ns/1ps

module wb_wu_front
(
    input  logic                                clk2x,
    input  logic                                rst_n,
    // Wishbone slave
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [stream_mac_pkg::WB_AW-1:0]    wb_adr,
    input  logic [31:0]                         wb_wdata,
    output logic [31:0]                         wb_rdata,
    output logic                                wb_ack,
    // Bank write port shared by both readers
    output logic                                bank_we_a,
    output logic                                bank_we_b,
    output logic [stream_mac_pkg::ADDR_W-1:0]   bank_addr,
    output logic [stream_mac_pkg::DATA_W-1:0]   bank_wdata,
    // Work-unit launch
    output logic                                start_a,
    output logic                                start_b,
    output logic [stream_mac_pkg::ADDR_W-1:0]   base_a,
    output logic [stream_mac_pkg::ADDR_W-1:0]   base_b,
    output logic [stream_mac_pkg::LEN_W-1:0]    len,
    output logic                                comb_start,
    output logic                                scale_en,
    output logic [stream_mac_pkg::DATA_W-1:0]   scale,
    // Completion from the combiner
    input  logic                                done,
    input  logic [stream_mac_pkg::ACC_W-1:0]    result
);

    stream_mac_pkg::wu_word_t wu;
    logic [1:0] region;
    logic       wr_en;
    logic       op_dot;
    logic       op_scale;
    logic       accept;
    logic       busy_q;
    logic       done_q;

    // ----------------------------------------
    // Wishbone handshake
    // ----------------------------------------
    // Ack one cycle after the strobe and never two in a row
    always_ff @(posedge clk2x or negedge rst_n)
    begin
        if (!rst_n)
            wb_ack <= 1'b0;
        else
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
    end

    // Writes land on the ack cycle
    assign wr_en  = wb_ack && wb_cyc && wb_stb && wb_we;
    assign region = wb_adr[stream_mac_pkg::WB_AW-1 -: 2];

    // Bank writes dropped while a work unit runs
    assign bank_we_a  = wr_en && !busy_q && (region == stream_mac_pkg::BANK_A_SEL);
    assign bank_we_b  = wr_en && !busy_q && (region == stream_mac_pkg::BANK_B_SEL);
    assign bank_addr  = wb_adr[stream_mac_pkg::ADDR_W-1:0];
    assign bank_wdata = wb_wdata[stream_mac_pkg::DATA_W-1:0];

    // Only status and result read back nonzero
    always_comb
    begin
        wb_rdata = '0;
        if (wb_adr == stream_mac_pkg::REG_CTRL)
        begin
            wb_rdata[stream_mac_pkg::STAT_BUSY_BIT] = busy_q;
            wb_rdata[stream_mac_pkg::STAT_DONE_BIT] = done_q;
        end
        else if (wb_adr == stream_mac_pkg::REG_RESULT)
            wb_rdata = result;
    end

    // ----------------------------------------
    // Work-unit decode
    // ----------------------------------------
    assign wu       = wb_wdata;
    // Opcode sits in the same bits in both views
    assign op_dot   = (wu.dot.op == stream_mac_pkg::OP_DOT);
    assign op_scale = (wu.dot.op == stream_mac_pkg::OP_SCALE);
    // Unknown opcodes and writes while busy are acked and dropped
    assign accept   = wr_en && !busy_q && (wb_adr == stream_mac_pkg::REG_CTRL)
                      && (op_dot || op_scale);

    // Launch pulses and status flags
    always_ff @(posedge clk2x or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            start_a    <= 1'b0;
            start_b    <= 1'b0;
            comb_start <= 1'b0;
            scale_en   <= 1'b0;
        end
        else
        begin
            start_a    <= accept;
            // Stream B idles in scale mode
            start_b    <= accept && op_dot;
            comb_start <= accept;
            if (accept)
            begin
                busy_q   <= 1'b1;
                done_q   <= 1'b0;
                scale_en <= op_scale;
            end
            else if (done)
            begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // Work-unit fields held for the whole run
    always_ff @(posedge clk2x)
    begin
        if (accept)
        begin
            // Length and base A share their bits in both views
            len    <= wu.dot.len;
            base_a <= wu.dot.base_a;
            if (op_dot)
                base_b <= wu.dot.base_b;
            else
                // Zero-extend the 10-bit constant
                scale  <= {{(stream_mac_pkg::DATA_W - $bits(wu.scale.scale)){1'b0}},
                           wu.scale.scale};
        end
    end

endmodule

//--- hdl/stream_mac_pkg.sv
// Stream MAC shared definitions
// Widths, register map, opcodes and the work-unit word layout

package stream_mac_pkg;

    // ----------------------------------------
    // Datapath widths
    // ----------------------------------------
    localparam int DATA_W = 16;
    localparam int ADDR_W = 10;
    localparam int LEN_W  = 8;
    // Accumulator wraps modulo 2^32
    localparam int ACC_W  = 32;
    localparam int WB_AW  = 12;

    // ----------------------------------------
    // Wishbone register map
    // ----------------------------------------
    // Write sends a work unit, read returns status
    localparam logic [WB_AW-1:0] REG_CTRL   = 12'd0;
    localparam logic [WB_AW-1:0] REG_RESULT = 12'd1;
    // Top two address bits pick the bank, low ten give the word
    localparam logic [1:0] BANK_A_SEL = 2'b01;
    localparam logic [1:0] BANK_B_SEL = 2'b10;

    // Status word bits
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;

    // Work-unit opcodes
    localparam logic [3:0] OP_DOT   = 4'd1;
    localparam logic [3:0] OP_SCALE = 4'd2;

    // ----------------------------------------
    // Work-unit word, two views of 32 bits
    // ----------------------------------------
    typedef struct packed {
        logic [3:0]        op;
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] base_a;
        logic [ADDR_W-1:0] base_b;
    } wu_dot_t;

    // Same layout, last field is the constant multiplier
    typedef struct packed {
        logic [3:0]        op;
        logic [LEN_W-1:0]  len;
        logic [ADDR_W-1:0] base_a;
        logic [ADDR_W-1:0] scale;
    } wu_scale_t;

    typedef union packed {
        wu_dot_t   dot;
        wu_scale_t scale;
    } wu_word_t;

endpackage
